//--- bench/status_tb.sv
// status subsystem testbench
`timescale 1ns/1ps

module status_tb;

	localparam int RECO_WORDS = 16;
	localparam int MAX_CYCLES = 20 * 200; // ~200 commands, 20 cycles each

	logic        clk_status, arst;
	logic        cmd_valid, cmd_ready, cmd_write, rsp_valid, rsp_ready, rsp_error;
	logic [15:0] cmd_addr;
	logic [31:0] cmd_wdata, rsp_rdata;
	logic        cfp_mod_lopwr, cfp_mod_rst, cfp_tx_dis, cfp_mod_abs, cfp_rx_los, cfp_glb_alrm;
	logic [3:1]  cfp_prg_cntl, cfp_prg_alrm;

	logic [31:0] reco_model [RECO_WORDS]; // reference state
	logic [5:0]  ctrl_model, live_model, sticky_model;
	logic [32:0] exp_q [$];              // {error, rdata} per issued command
	int          errors, checks, cycles, test_start;

	status_subsystem_top #(.TIMEOUT_CYCLES(16), .RECO_WORDS(RECO_WORDS)) DUT (.*);

	initial begin
		clk_status = 1'b0;
		forever #20 clk_status = ~clk_status;
	end

	////////////////////////////////////////////////////////////
	// reference model of the address map
	////////////////////////////////////////////////////////////

	function automatic logic [32:0] ref_response(input logic wr, input logic [15:0] addr,
			input logic [31:0] wdata);
		logic [32:0] res;
		logic [7:0]  rsel;
		int          idx;
		res  = '0; // writes and mapped reads end without error
		rsel = addr[7:0];
		idx  = int'(addr[6:0]) % RECO_WORDS; // window offset wraps on the store
		if (addr[15:7] == 9'h00C) begin // 0x600..0x67F
			if (wr) reco_model[idx] = wdata;
			else res[31:0] = reco_model[idx];
		end else if (addr[15:8] == 8'h02) begin // optics block
			if (wr && rsel == 8'd1) ctrl_model = wdata[5:0];
			if (wr && rsel == 8'd3) sticky_model = (sticky_model & ~wdata[5:0]) | live_model;
			if (!wr) begin
				case (rsel)
					8'd0: res[31:0] = status_pkg::OPTICS_ID;
					8'd1: res[5:0] = ctrl_model;
					8'd2: res[5:0] = live_model;
					8'd3: res[5:0] = sticky_model;
					default: res = '0; // unused registers read zero
				endcase
			end
		end else if (!wr) begin
			res = {1'b1, 32'd0}; // nobody answers, host times out
		end
		return res;
	endfunction

	////////////////////////////////////////////////////////////
	// stimulus helpers, all called on the falling edge
	////////////////////////////////////////////////////////////

	task automatic do_command(input logic wr, input logic [15:0] addr, input logic [31:0] wdata);
		int hold;
		hold = int'($urandom % 4); // response back-pressure
		exp_q.push_back(ref_response(wr, addr, wdata));
		cmd_valid = 1'b1;
		cmd_write = wr;
		cmd_addr  = addr;
		cmd_wdata = wdata;
		while (!cmd_ready) @(negedge clk_status);
		@(negedge clk_status); // accepted on the edge just passed
		cmd_valid = 1'b0;
		while (!rsp_valid) @(negedge clk_status);
		repeat (hold) @(negedge clk_status);
		rsp_ready = 1'b1;
		@(negedge clk_status);
		rsp_ready = 1'b0;
	endtask

	task automatic set_cfp_inputs(input logic [5:0] v);
		{cfp_prg_alrm, cfp_glb_alrm, cfp_rx_los, cfp_mod_abs} = v;
		live_model   = v;
		sticky_model = sticky_model | v;
		repeat (5) @(negedge clk_status); // synchronizer plus margin
	endtask

	task automatic end_test(input string name);
		$display("test %s: %0d errors", name, errors - test_start);
		test_start = errors;
	endtask

	////////////////////////////////////////////////////////////
	// response checker
	////////////////////////////////////////////////////////////

	logic        held;
	logic [32:0] held_rsp, exp_rsp;

	always @(posedge clk_status) begin
		if (arst) begin
			held = 1'b0;
		end else begin
			if (held) begin // stalled response must not move
				checks++;
				assert (rsp_valid && {rsp_error, rsp_rdata} == held_rsp && !cmd_ready) else begin
					errors++;
					$display("mismatch at %0t: response changed while stalled", $time);
				end
			end
			if (rsp_valid && rsp_ready) begin
				checks++;
				assert (exp_q.size() != 0) else begin
					errors++;
					$display("a response arrived with no command outstanding at %0t", $time);
				end
				if (exp_q.size() != 0) begin
					exp_rsp = exp_q.pop_front();
					assert ({rsp_error, rsp_rdata} == exp_rsp) else begin
						errors++;
						$display("mismatch at %0t: addr %h gave %b/%h, expected %b/%h",
							$time, cmd_addr, rsp_error, rsp_rdata, exp_rsp[32], exp_rsp[31:0]);
					end
				end
			end
			held     = rsp_valid && !rsp_ready;
			held_rsp = {rsp_error, rsp_rdata};
		end
	end

	// watchdog
	always @(posedge clk_status) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Result: FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] v;
		logic [6:0]  off;
		void'($urandom(56329));
		errors     = 0;
		checks     = 0;
		cycles     = 0;
		test_start = 0;
		arst       = 1'b1;
		cmd_valid  = 1'b0;
		cmd_write  = 1'b0;
		cmd_addr   = '0;
		cmd_wdata  = '0;
		rsp_ready  = 1'b0;
		{cfp_prg_alrm, cfp_glb_alrm, cfp_rx_los, cfp_mod_abs} = '0;
		for (int i = 0; i < RECO_WORDS; i++) reco_model[i] = '0;
		ctrl_model   = 6'b000_101; // lopwr, module in reset, tx off
		live_model   = '0;
		sticky_model = '0;
		repeat (5) @(negedge clk_status);
		arst = 1'b0;
		@(negedge clk_status);

		// 1: reset values on pins and registers
		checks++;
		assert (cfp_mod_lopwr && !cfp_mod_rst && cfp_tx_dis && cfp_prg_cntl == 3'd0
				&& cmd_ready && !rsp_valid) else begin
			errors++;
			$display("mismatch at %0t: outputs differ from the reset state", $time);
		end
		do_command(1'b0, 16'h0200, 32'd0);
		do_command(1'b0, 16'h0201, 32'd0);
		end_test("reset state");

		// 2: control register to pins
		repeat (8) begin
			v = $urandom;
			do_command(1'b1, 16'h0201, v);
			checks++;
			assert ({cfp_prg_cntl, cfp_tx_dis, cfp_mod_rst, cfp_mod_lopwr} == ctrl_model) else begin
				errors++;
				$display("mismatch at %0t: CFP control pins do not follow %h", $time, v);
			end
			do_command(1'b0, 16'h0201, 32'd0);
		end
		end_test("control register");

		// 3: live status and sticky alarms
		set_cfp_inputs(6'b101_011);
		do_command(1'b0, 16'h0202, 32'd0);
		do_command(1'b0, 16'h0203, 32'd0);
		set_cfp_inputs(6'b010_100);
		do_command(1'b0, 16'h0202, 32'd0);
		set_cfp_inputs(6'b000_000); // pulses gone, latch keeps them
		do_command(1'b0, 16'h0202, 32'd0);
		do_command(1'b0, 16'h0203, 32'd0);
		do_command(1'b1, 16'h0203, 32'h0000_0007); // clear low three bits only
		do_command(1'b0, 16'h0203, 32'd0);
		do_command(1'b1, 16'h0203, 32'h0000_003F);
		do_command(1'b0, 16'h0203, 32'd0);
		end_test("live status and alarms");

		// 4: reconfiguration window, random mix
		repeat (150) begin
			off = 7'($urandom % 128);
			do_command(1'($urandom % 2), 16'h0600 + 16'(off), $urandom);
		end
		end_test("reconfiguration window");

		// 5: unmapped reads time out, writes complete
		do_command(1'b0, 16'h0000, 32'd0);
		do_command(1'b0, 16'h0680, 32'd0);
		do_command(1'b0, 16'h05FF, 32'd0);
		do_command(1'b0, 16'h0300, 32'd0);
		do_command(1'b0, 16'hFFFF, 32'd0);
		do_command(1'b0, 16'h0210, 32'd0); // inside the block, reads zero
		do_command(1'b1, 16'h0000, 32'h1234_5678);
		do_command(1'b1, 16'h0700, 32'h8765_4321);
		end_test("unmapped addresses");

		// 6: held response blocks a waiting command
		exp_q.push_back(ref_response(1'b0, 16'h0605, 32'd0));
		exp_q.push_back(ref_response(1'b1, 16'h0605, 32'hA5A5_0F0F));
		cmd_valid = 1'b1;
		cmd_write = 1'b0;
		cmd_addr  = 16'h0605;
		while (!cmd_ready) @(negedge clk_status);
		@(negedge clk_status);
		cmd_write = 1'b1; // second command stays valid throughout
		cmd_wdata = 32'hA5A5_0F0F;
		repeat (10) begin // read latency, then a long stall
			checks++;
			assert (!cmd_ready) else begin
				errors++;
				$display("mismatch at %0t: cmd_ready high with a response pending", $time);
			end
			@(negedge clk_status);
		end
		checks++;
		assert (rsp_valid) else begin
			errors++;
			$display("mismatch at %0t: read response missing after 10 cycles", $time);
		end
		rsp_ready = 1'b1;
		@(negedge clk_status);
		rsp_ready = 1'b0;
		while (!cmd_ready) @(negedge clk_status);
		@(negedge clk_status);
		cmd_valid = 1'b0;
		while (!rsp_valid) @(negedge clk_status);
		rsp_ready = 1'b1;
		@(negedge clk_status);
		rsp_ready = 1'b0;
		do_command(1'b0, 16'h0605, 32'd0); // the queued write landed
		end_test("back-pressure");

		checks++;
		assert (exp_q.size() == 0) else begin
			errors++;
			$display("%0d responses never arrived", exp_q.size());
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- filelist.f
rtl/status_pkg.sv
rtl/status_host.sv
rtl/status_read_combine.sv
rtl/optics_ctrl_regs.sv
rtl/reco_window.sv
rtl/status_subsystem_top.sv
bench/status_tb.sv

//--- rtl/optics_ctrl_regs.sv
// CFP optics control registers
`timescale 1ns/1ps

module optics_ctrl_regs (
	input  logic                          clk_status,
	input  logic                          arst,
	// status bus
	input  logic [status_pkg::ADDR_W-1:0] status_addr,
	input  logic                          status_read,
	input  logic                          status_write,
	input  logic [status_pkg::DATA_W-1:0] status_writedata,
	output logic [status_pkg::DATA_W-1:0] readdata,
	output logic                          readdata_valid,
	// CFP module controls
	output logic                          cfp_mod_lopwr,
	output logic                          cfp_mod_rst,  // active low
	output logic                          cfp_tx_dis,
	output logic [3:1]                    cfp_prg_cntl,
	// CFP module status, asynchronous
	input  logic                          cfp_mod_abs,
	input  logic                          cfp_rx_los,
	input  logic                          cfp_glb_alrm,
	input  logic [3:1]                    cfp_prg_alrm
);

	status_pkg::status_addr_u addr_u;
	logic       hit;        // block decode
	logic [7:0] regsel;
	logic [5:0] ctrl_reg;   // lopwr, rst_n, tx_dis, prg_cntl
	logic [5:0] pins_raw;
	logic [5:0] sync_meta;  // first synchronizer stage
	logic [5:0] live;       // synchronized inputs
	logic [5:0] sticky;     // latched alarms

	assign addr_u = status_addr;
	assign hit    = (addr_u.blk.block == status_pkg::OPTICS_BLOCK);
	assign regsel = addr_u.blk.regsel;

	// same bit order as register 2
	assign pins_raw = {cfp_prg_alrm, cfp_glb_alrm, cfp_rx_los, cfp_mod_abs};

	////////////////////////////////////////////////////////////
	// input synchronizers and alarm latch
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_status) begin
		if (arst) begin
			sync_meta <= '0;
			live      <= '0;
			sticky    <= '0;
		end else begin
			sync_meta <= pins_raw;
			live      <= sync_meta;
			if (status_write && hit && regsel == 8'd3)
				sticky <= (sticky & ~status_writedata[5:0]) | live; // write 1 to clear
			else
				sticky <= sticky | live; // new alarm wins over clear
		end
	end

	////////////////////////////////////////////////////////////
	// control register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_status) begin
		if (arst) ctrl_reg <= status_pkg::CTRL_RESET[5:0];
		else if (status_write && hit && regsel == 8'd1) ctrl_reg <= status_writedata[5:0];
	end

	assign cfp_mod_lopwr = ctrl_reg[0];
	assign cfp_mod_rst   = ctrl_reg[1];
	assign cfp_tx_dis    = ctrl_reg[2];
	assign cfp_prg_cntl  = ctrl_reg[5:3];

	////////////////////////////////////////////////////////////
	// read return, one cycle after the strobe
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_status) begin
		if (arst) readdata_valid <= 1'b0;
		else readdata_valid <= status_read && hit;
	end

	always_ff @(posedge clk_status) begin
		if (status_read && hit) begin
			case (regsel)
				8'd0: readdata <= status_pkg::OPTICS_ID;
				8'd1: readdata <= {26'd0, ctrl_reg};
				8'd2: readdata <= {26'd0, live};
				8'd3: readdata <= {26'd0, sticky};
				default: readdata <= '0; // unused registers in the block
			endcase
		end
	end

endmodule

//--- rtl/reco_window.sv
// transceiver reconfiguration window
`timescale 1ns/1ps

module reco_window #(
	parameter int RECO_WORDS = 16
) (
	input  logic                          clk_status,
	input  logic                          arst,
	input  logic [status_pkg::ADDR_W-1:0] status_addr,
	input  logic                          status_read,
	input  logic                          status_write,
	input  logic [status_pkg::DATA_W-1:0] status_writedata,
	output logic [status_pkg::DATA_W-1:0] readdata,
	output logic                          readdata_valid
);

	localparam int IDX_W = (RECO_WORDS > 1) ? $clog2(RECO_WORDS) : 1;

	logic                          read_r;
	logic                          write_r;
	logic [status_pkg::ADDR_W-1:0] addr_r;
	logic [status_pkg::DATA_W-1:0] wdata_r;
	status_pkg::status_addr_u      addr_u;
	logic                          hit;    // page decode on the registered copy
	logic [IDX_W-1:0]              idx;    // store index
	logic [status_pkg::DATA_W-1:0] store [RECO_WORDS];

	// bus register stage, no wait state so it loads every cycle
	always_ff @(posedge clk_status) begin
		if (arst) begin
			read_r  <= 1'b0;
			write_r <= 1'b0;
		end else begin
			read_r  <= status_read;
			write_r <= status_write;
		end
	end

	always_ff @(posedge clk_status) begin
		addr_r  <= status_addr;
		wdata_r <= status_writedata;
	end

	assign addr_u = addr_r;
	assign hit    = (addr_u.win.page == status_pkg::RECO_PAGE);
	assign idx    = IDX_W'(addr_u.win.offset % RECO_WORDS); // offset wraps on the store

	// register store, stands in for the reconfig controller
	always_ff @(posedge clk_status) begin
		if (arst) begin
			for (int i = 0; i < RECO_WORDS; i++) store[i] <= '0;
		end else if (write_r && hit) begin
			store[idx] <= wdata_r;
		end
	end

	assign readdata_valid = read_r && hit;
	assign readdata       = store[idx]; // combinational from the registered address

endmodule

//--- rtl/status_host.sv
// status bus host engine
`timescale 1ns/1ps

module status_host #(
	parameter int TIMEOUT_CYCLES = 16
) (
	input  logic                          clk_status,
	input  logic                          arst,
	// command port
	input  logic                          cmd_valid,
	output logic                          cmd_ready,
	input  logic                          cmd_write,
	input  logic [status_pkg::ADDR_W-1:0] cmd_addr,
	input  logic [status_pkg::DATA_W-1:0] cmd_wdata,
	// response port
	output logic                          rsp_valid,
	input  logic                          rsp_ready,
	output logic [status_pkg::DATA_W-1:0] rsp_rdata,
	output logic                          rsp_error,
	// status bus
	output logic [status_pkg::ADDR_W-1:0] status_addr,
	output logic                          status_read,
	output logic                          status_write,
	output logic [status_pkg::DATA_W-1:0] status_writedata,
	input  logic [status_pkg::DATA_W-1:0] status_readdata,
	input  logic                          status_readdata_valid,
	input  logic                          collision
);

	localparam logic [1:0] ST_IDLE    = 2'd0;
	localparam logic [1:0] ST_STROBE  = 2'd1;
	localparam logic [1:0] ST_WAIT    = 2'd2;
	localparam logic [1:0] ST_RESPOND = 2'd3;
	localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

	logic [1:0]       state;
	logic [CNT_W-1:0] wait_cnt; // cycles spent waiting for a return
	logic             write_q;  // captured direction

	assign cmd_ready    = (state == ST_IDLE); // one command outstanding
	assign rsp_valid    = (state == ST_RESPOND);
	assign status_read  = (state == ST_STROBE) && !write_q; // single-cycle strobes
	assign status_write = (state == ST_STROBE) && write_q;

	// control FSM
	always_ff @(posedge clk_status) begin
		if (arst) begin
			state    <= ST_IDLE;
			wait_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (cmd_valid) state <= ST_STROBE;
				end
				ST_STROBE: begin
					wait_cnt <= '0;
					state    <= write_q ? ST_RESPOND : ST_WAIT; // writes are posted
				end
				ST_WAIT: begin
					if (status_readdata_valid || collision) state <= ST_RESPOND;
					else if (wait_cnt == CNT_W'(TIMEOUT_CYCLES - 1)) state <= ST_RESPOND;
					else wait_cnt <= wait_cnt + 1'b1;
				end
				default: begin
					if (rsp_ready) state <= ST_IDLE; // hold until taken
				end
			endcase
		end
	end

	// command capture and response data
	always_ff @(posedge clk_status) begin
		if (cmd_valid && cmd_ready) begin
			status_addr      <= cmd_addr;
			status_writedata <= cmd_wdata;
			write_q          <= cmd_write;
		end
		if (state == ST_STROBE && write_q) begin
			rsp_rdata <= '0;
			rsp_error <= 1'b0;
		end
		if (state == ST_WAIT) begin
			if (collision) begin // two clients answered
				rsp_rdata <= '0;
				rsp_error <= 1'b1;
			end else if (status_readdata_valid) begin
				rsp_rdata <= status_readdata;
				rsp_error <= 1'b0;
			end else begin // timeout value, kept only on the last wait cycle
				rsp_rdata <= '0;
				rsp_error <= 1'b1;
			end
		end
	end

endmodule

//--- rtl/status_pkg.sv
// status bus shared definitions

package status_pkg;

	////////////////////////////////////////////////////////////
	// bus widths
	////////////////////////////////////////////////////////////

	localparam int ADDR_W = 16; // word address
	localparam int DATA_W = 32;

	////////////////////////////////////////////////////////////
	// address decode views
	////////////////////////////////////////////////////////////

	// one address word, read two ways
	typedef union packed {
		struct packed {
			logic [8:0] page;   // 128-word page
			logic [6:0] offset;
		} win;                  // reconfig window view
		struct packed {
			logic [7:0] block;  // 256-word block
			logic [7:0] regsel;
		} blk;                  // optics block view
	} status_addr_u;

	// address map
	localparam logic [8:0] RECO_PAGE    = 9'h00C; // 0x600..0x67F
	localparam logic [7:0] OPTICS_BLOCK = 8'h02;  // 0x200..0x2FF

	////////////////////////////////////////////////////////////
	// optics block constants
	////////////////////////////////////////////////////////////

	localparam logic [DATA_W-1:0] OPTICS_ID = 32'hCF90_0001; // identity word

	// lopwr on, mod_rst low (held in reset), tx disabled, prg_cntl 0
	localparam logic [DATA_W-1:0] CTRL_RESET = 32'h0000_0005;

endpackage

//--- rtl/status_read_combine.sv
// status read return merge
`timescale 1ns/1ps

module status_read_combine #(
	parameter int NUM_CLIENTS = 2
) (
	input  logic                                      clk_status,
	input  logic                                      arst,
	input  logic [NUM_CLIENTS*status_pkg::DATA_W-1:0] client_readdata,
	input  logic [NUM_CLIENTS-1:0]                    client_readdata_valid,
	output logic [status_pkg::DATA_W-1:0]             status_readdata,
	output logic                                      status_readdata_valid,
	output logic                                      collision
);

	logic [status_pkg::DATA_W-1:0] merged; // OR of answering clients
	logic any_v;
	logic multi_v;                         // more than one answer this cycle

	always_comb begin
		merged  = '0;
		any_v   = 1'b0;
		multi_v = 1'b0;
		for (int i = 0; i < NUM_CLIENTS; i++) begin
			if (client_readdata_valid[i]) begin
				merged  = merged | client_readdata[i*status_pkg::DATA_W +: status_pkg::DATA_W];
				multi_v = multi_v | any_v; // already had one
				any_v   = 1'b1;
			end
		end
	end

	always_ff @(posedge clk_status) begin
		if (arst) begin
			status_readdata_valid <= 1'b0;
			collision             <= 1'b0;
		end else begin
			status_readdata_valid <= any_v;
			collision             <= multi_v; // one-cycle flag
		end
	end

	always_ff @(posedge clk_status) status_readdata <= merged; // payload, no reset

endmodule

//--- rtl/status_subsystem_top.sv
// status management subsystem
`timescale 1ns/1ps

module status_subsystem_top #(
	parameter int TIMEOUT_CYCLES = 16,
	parameter int RECO_WORDS     = 16
) (
	input  logic                          clk_status,
	input  logic                          arst,
	// command port
	input  logic                          cmd_valid,
	output logic                          cmd_ready,
	input  logic                          cmd_write,
	input  logic [status_pkg::ADDR_W-1:0] cmd_addr,
	input  logic [status_pkg::DATA_W-1:0] cmd_wdata,
	output logic                          rsp_valid,
	input  logic                          rsp_ready,
	output logic [status_pkg::DATA_W-1:0] rsp_rdata,
	output logic                          rsp_error,
	// CFP pins
	output logic                          cfp_mod_lopwr,
	output logic                          cfp_mod_rst,
	output logic                          cfp_tx_dis,
	output logic [3:1]                    cfp_prg_cntl,
	input  logic                          cfp_mod_abs,
	input  logic                          cfp_rx_los,
	input  logic                          cfp_glb_alrm,
	input  logic [3:1]                    cfp_prg_alrm
);

	localparam int NUM_CLIENTS = 2; // optics, reconfig

	// shared status bus
	logic [status_pkg::ADDR_W-1:0] status_addr;
	logic                          status_read;
	logic                          status_write;
	logic [status_pkg::DATA_W-1:0] status_writedata;
	logic [status_pkg::DATA_W-1:0] status_readdata;
	logic                          status_readdata_valid;
	logic                          collision;

	// client returns
	logic [status_pkg::DATA_W-1:0] readdata_cfp, readdata_reco;
	logic                          readdata_valid_cfp, readdata_valid_reco;

	////////////////////////////////////////////////////////////
	// host
	////////////////////////////////////////////////////////////

	status_host #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) host (
		.clk_status, .arst,
		.cmd_valid, .cmd_ready, .cmd_write, .cmd_addr, .cmd_wdata,
		.rsp_valid, .rsp_ready, .rsp_rdata, .rsp_error,
		.status_addr, .status_read, .status_write, .status_writedata,
		.status_readdata, .status_readdata_valid, .collision
	);

	////////////////////////////////////////////////////////////
	// clients
	////////////////////////////////////////////////////////////

	optics_ctrl_regs cc (
		.clk_status, .arst,
		.status_addr, .status_read, .status_write, .status_writedata,
		.readdata(readdata_cfp),
		.readdata_valid(readdata_valid_cfp),
		.cfp_mod_lopwr, .cfp_mod_rst, .cfp_tx_dis, .cfp_prg_cntl,
		.cfp_mod_abs, .cfp_rx_los, .cfp_glb_alrm, .cfp_prg_alrm
	);

	reco_window #(.RECO_WORDS(RECO_WORDS)) rw (
		.clk_status, .arst,
		.status_addr, .status_read, .status_write, .status_writedata,
		.readdata(readdata_reco),
		.readdata_valid(readdata_valid_reco)
	);

	////////////////////////////////////////////////////////////
	// read merge
	////////////////////////////////////////////////////////////

	status_read_combine #(.NUM_CLIENTS(NUM_CLIENTS)) arc (
		.clk_status, .arst,
		.client_readdata({readdata_cfp, readdata_reco}),
		.client_readdata_valid({readdata_valid_cfp, readdata_valid_reco}),
		.status_readdata, .status_readdata_valid, .collision
	);

endmodule

//--- run.sh
#!/usr/bin/env bash
# compile the status subsystem testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f filelist.f --top-module status_tb -o status_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

sim_out=$(./obj_dir/status_sim)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Result: PASSED"; then
	exit 0
fi
exit 1
